/* rtl/fp_defs.svh */
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// Single-precision field layout
`define FP_EXP_W    8
`define FP_FRAC_W   23
`define FP_SIG_W    24

// Exponent encoding
`define FP_EXP_BIAS 127
`define FP_EXP_INF  255

`endif

/* rtl/fp_types_pkg.sv */
`default_nettype none

`include "fp_defs.svh"

package fp_types_pkg;

    typedef logic [`FP_EXP_W-1:0] fp_exp_t;

    // Significand with the hidden one
    typedef logic [`FP_SIG_W-1:0] fp_sig_t;

    // Aligned sum, top bit is the carry
    typedef logic [`FP_SIG_W:0] fp_sum_t;

    typedef logic [2*`FP_SIG_W-1:0] fp_prod_t;

    typedef struct packed {
        logic                  sign;
        fp_exp_t               exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp32_t;

endpackage

`default_nettype wire

/* rtl/alu_op_pkg.sv */
`default_nettype none

package alu_op_pkg;

    typedef enum logic [2:0] {
        FADD = 3'd0,
        FSUB = 3'd1,
        FMUL = 3'd2,
        FNEG = 3'd3,
        FABS = 3'd4,
        FEQ  = 3'd5,
        FSLT = 3'd6
    } alu_op_e;

endpackage

`default_nettype wire

/* rtl/fp_pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Unpack to arithmetic
interface align_if;
    import fp_types_pkg::*;
    import alu_op_pkg::*;

    alu_op_e op;
    fp32_t   op_a;
    fp32_t   op_b;
    logic    sign_a;
    logic    sign_b;
    fp_sig_t sig_a;
    fp_sig_t sig_b;
    fp_exp_t exp_diff;
    logic    a_larger;
    fp_exp_t aligned_exp;
    logic    item_valid;

    modport source (output op, op_a, op_b, sign_a, sign_b, sig_a, sig_b,
                    exp_diff, a_larger, aligned_exp, item_valid);
    modport sink   (input op, op_a, op_b, sign_a, sign_b, sig_a, sig_b,
                    exp_diff, a_larger, aligned_exp, item_valid);
endinterface

// Arithmetic to normalize
interface arith_if;
    import fp_types_pkg::*;
    import alu_op_pkg::*;

    alu_op_e  op;
    fp32_t    op_a;
    fp32_t    op_b;
    fp_sum_t  sum;
    fp_prod_t product;
    fp_exp_t  res_exp;
    logic     res_sign;
    logic     item_valid;

    modport source (output op, op_a, op_b, sum, product, res_exp, res_sign, item_valid);
    modport sink   (input op, op_a, op_b, sum, product, res_exp, res_sign, item_valid);
endinterface

// Normalize to pack
interface norm_if;
    import fp_types_pkg::*;
    import alu_op_pkg::*;

    alu_op_e op;
    fp32_t   op_a;
    fp32_t   op_b;
    fp_sig_t norm_sig;
    fp_exp_t norm_exp;
    logic    norm_sign;
    logic    round_up;
    logic    item_valid;

    modport source (output op, op_a, op_b, norm_sig, norm_exp, norm_sign, round_up, item_valid);
    modport sink   (input op, op_a, op_b, norm_sig, norm_exp, norm_sign, round_up, item_valid);
endinterface

`default_nettype wire

/* rtl/fp_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  fp_types_pkg::fp32_t op_a,
    input  fp_types_pkg::fp32_t op_b,
    input  alu_op_pkg::alu_op_e instruction,
    align_if.source             dn
);
    import fp_types_pkg::*;
    import alu_op_pkg::*;

    alu_op_e op_q;
    logic    valid_q;
    fp32_t   a_q;
    fp32_t   b_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q    <= FADD;
            valid_q <= 1'b0;
        end else if (enable) begin
            op_q    <= instruction;
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            a_q <= op_a;
            b_q <= op_b;
        end
    end

    always_comb begin
        dn.op         = op_q;
        dn.op_a       = a_q;
        dn.op_b       = b_q;
        dn.item_valid = valid_q;
        dn.sign_a     = a_q.sign;
        // Subtract is an add with op_b negated
        dn.sign_b     = (op_q == FSUB) ? ~b_q.sign : b_q.sign;
        dn.sig_a      = {1'b1, a_q.frac};
        dn.sig_b      = {1'b1, b_q.frac};

        if (a_q.exp >= b_q.exp) begin
            dn.exp_diff    = a_q.exp - b_q.exp;
            dn.aligned_exp = a_q.exp;
            dn.a_larger    = 1'b1;
        end else begin
            dn.exp_diff    = b_q.exp - a_q.exp;
            dn.aligned_exp = b_q.exp;
            dn.a_larger    = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/fp_arith.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_defs.svh"

module fp_arith (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    align_if.sink    up,
    arith_if.source  dn
);
    import fp_types_pkg::*;
    import alu_op_pkg::*;

    alu_op_e op_q;
    logic    valid_q;
    fp32_t   a_q;
    fp32_t   b_q;
    logic    sign_a_q;
    logic    sign_b_q;
    fp_sig_t sig_a_q;
    fp_sig_t sig_b_q;
    fp_exp_t exp_diff_q;
    logic    a_larger_q;
    fp_exp_t aligned_exp_q;
    fp_sum_t ext_a;
    fp_sum_t ext_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q    <= FADD;
            valid_q <= 1'b0;
        end else if (enable) begin
            op_q    <= up.op;
            valid_q <= up.item_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            a_q           <= up.op_a;
            b_q           <= up.op_b;
            sign_a_q      <= up.sign_a;
            sign_b_q      <= up.sign_b;
            sig_a_q       <= up.sig_a;
            sig_b_q       <= up.sig_b;
            exp_diff_q    <= up.exp_diff;
            a_larger_q    <= up.a_larger;
            aligned_exp_q <= up.aligned_exp;
        end
    end

    // ==================================================
    // Significand add/subtract and multiply
    // ==================================================
    always_comb begin
        ext_a = {1'b0, sig_a_q};
        ext_b = {1'b0, sig_b_q};
        // Bits shifted out of the smaller operand are dropped
        if (a_larger_q) begin
            ext_b = ext_b >> exp_diff_q;
        end else begin
            ext_a = ext_a >> exp_diff_q;
        end

        dn.op         = op_q;
        dn.op_a       = a_q;
        dn.op_b       = b_q;
        dn.item_valid = valid_q;
        dn.sum        = '0;
        dn.product    = '0;
        dn.res_exp    = '0;
        dn.res_sign   = 1'b0;

        case (op_q)
            FADD, FSUB: begin
                dn.res_exp = aligned_exp_q;
                if (sign_a_q == sign_b_q) begin
                    dn.sum      = ext_a + ext_b;
                    dn.res_sign = sign_a_q;
                end else if (ext_a >= ext_b) begin
                    dn.sum      = ext_a - ext_b;
                    dn.res_sign = sign_a_q;
                end else begin
                    dn.sum      = ext_b - ext_a;
                    dn.res_sign = sign_b_q;
                end
            end
            FMUL: begin
                dn.product  = sig_a_q * sig_b_q;
                dn.res_exp  = a_q.exp + b_q.exp - fp_exp_t'(`FP_EXP_BIAS);
                dn.res_sign = sign_a_q ^ sign_b_q;
            end
            default: begin
                dn.sum = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/fp_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_defs.svh"

module fp_normalize (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    arith_if.sink    up,
    norm_if.source   dn
);
    import fp_types_pkg::*;
    import alu_op_pkg::*;

    alu_op_e    op_q;
    logic       valid_q;
    fp32_t      a_q;
    fp32_t      b_q;
    fp_sum_t    sum_q;
    fp_prod_t   prod_q;
    fp_exp_t    exp_q;
    logic       sign_q;
    logic [4:0] lead_shift;
    fp_sum_t    shifted;
    logic       guard;
    logic       round_bit;
    logic       sticky;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q    <= FADD;
            valid_q <= 1'b0;
        end else if (enable) begin
            op_q    <= up.op;
            valid_q <= up.item_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            a_q    <= up.op_a;
            b_q    <= up.op_b;
            sum_q  <= up.sum;
            prod_q <= up.product;
            exp_q  <= up.res_exp;
            sign_q <= up.res_sign;
        end
    end

    // Leading-one search, the highest set bit wins
    always_comb begin
        lead_shift = '0;
        for (int i = 0; i < `FP_SIG_W; i++) begin
            if (sum_q[i]) begin
                lead_shift = 5'(`FP_SIG_W - 1 - i);
            end
        end
        shifted = sum_q << lead_shift;
    end

    always_comb begin
        dn.op         = op_q;
        dn.op_a       = a_q;
        dn.op_b       = b_q;
        dn.item_valid = valid_q;
        dn.norm_sig   = '0;
        dn.norm_exp   = '0;
        dn.norm_sign  = 1'b0;
        guard         = 1'b0;
        round_bit     = 1'b0;
        sticky        = 1'b0;

        case (op_q)
            FADD, FSUB: begin
                if (sum_q[`FP_SIG_W]) begin
                    // Carry out, one step right
                    dn.norm_sig  = sum_q[`FP_SIG_W:1];
                    dn.norm_exp  = exp_q + 1'b1;
                    dn.norm_sign = sign_q;
                end else if (sum_q != '0 && fp_exp_t'(lead_shift) <= exp_q) begin
                    dn.norm_sig  = shifted[`FP_SIG_W-1:0];
                    dn.norm_exp  = exp_q - fp_exp_t'(lead_shift);
                    dn.norm_sign = sign_q;
                end
                // Zero sum and underflow leave +0
            end
            FMUL: begin
                dn.norm_sign = sign_q;
                if (prod_q[47]) begin
                    dn.norm_sig = prod_q[47:24];
                    dn.norm_exp = exp_q + 1'b1;
                    guard       = prod_q[23];
                    round_bit   = prod_q[22];
                    sticky      = |prod_q[21:0];
                end else begin
                    dn.norm_sig = prod_q[46:23];
                    dn.norm_exp = exp_q;
                    guard       = prod_q[22];
                    round_bit   = prod_q[21];
                    sticky      = |prod_q[20:0];
                end
            end
            default: begin
                dn.norm_sign = 1'b0;
            end
        endcase

        // Round to nearest even, only multiply sets guard
        dn.round_up = guard & (round_bit | sticky | dn.norm_sig[0]);
    end

endmodule

`default_nettype wire

/* rtl/fp_pack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_defs.svh"

module fp_pack (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    norm_if.sink                up,
    output fp_types_pkg::fp32_t result,
    output logic                valid
);
    import fp_types_pkg::*;
    import alu_op_pkg::*;

    alu_op_e                           op_q;
    logic                              valid_q;
    fp32_t                             a_q;
    fp32_t                             b_q;
    fp_sig_t                           sig_q;
    fp_exp_t                           exp_q;
    logic                              sign_q;
    logic                              round_up_q;
    fp_sum_t                           rounded;
    logic [`FP_EXP_W:0]                exp_r;
    logic [`FP_EXP_W+`FP_FRAC_W-1:0]   mag_a;
    logic [`FP_EXP_W+`FP_FRAC_W-1:0]   mag_b;
    logic                              a_less;
    logic                              a_equal;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q       <= FADD;
            valid_q    <= 1'b0;
            a_q        <= '0;
            b_q        <= '0;
            sig_q      <= '0;
            exp_q      <= '0;
            sign_q     <= 1'b0;
            round_up_q <= 1'b0;
        end else if (enable) begin
            op_q       <= up.op;
            valid_q    <= up.item_valid;
            a_q        <= up.op_a;
            b_q        <= up.op_b;
            sig_q      <= up.norm_sig;
            exp_q      <= up.norm_exp;
            sign_q     <= up.norm_sign;
            round_up_q <= up.round_up;
        end
    end

    // ==================================================
    // Rounding and comparison
    // ==================================================
    always_comb begin
        rounded = {1'b0, sig_q} + fp_sum_t'(round_up_q);
        // Rounding carry bumps the exponent
        exp_r   = {1'b0, exp_q} + {{`FP_EXP_W{1'b0}}, rounded[`FP_SIG_W]};

        mag_a   = {a_q.exp, a_q.frac};
        mag_b   = {b_q.exp, b_q.frac};
        a_equal = (mag_a == '0 && mag_b == '0) || (a_q == b_q);

        if (mag_a == '0 && mag_b == '0) begin
            a_less = 1'b0;
        end else if (a_q.sign != b_q.sign) begin
            a_less = a_q.sign;
        end else if (a_q.sign) begin
            // Both negative, larger magnitude is smaller
            a_less = mag_a > mag_b;
        end else begin
            a_less = mag_a < mag_b;
        end
    end

    always_comb begin
        result = '0;
        case (op_q)
            FADD, FSUB, FMUL: begin
                result.sign = sign_q;
                if (exp_r >= `FP_EXP_INF) begin
                    result.exp = '1;
                end else if (exp_r != '0) begin
                    result.exp  = exp_r[`FP_EXP_W-1:0];
                    result.frac = rounded[`FP_SIG_W] ? rounded[`FP_SIG_W-1:1]
                                                     : rounded[`FP_FRAC_W-1:0];
                end
            end
            FNEG: begin
                result      = a_q;
                result.sign = ~a_q.sign;
            end
            FABS: begin
                result      = a_q;
                result.sign = 1'b0;
            end
            FEQ: begin
                result = fp32_t'({31'd0, a_equal});
            end
            FSLT: begin
                result = fp32_t'({31'd0, a_less});
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign valid = valid_q;

endmodule

`default_nettype wire

/* rtl/fp_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  fp_types_pkg::fp32_t op_a,
    input  fp_types_pkg::fp32_t op_b,
    input  alu_op_pkg::alu_op_e instruction,
    output fp_types_pkg::fp32_t result,
    output logic                valid
);

    // Stage-to-stage bundles
    align_if i_align_if ();
    arith_if i_arith_if ();
    norm_if  i_norm_if ();

    fp_unpack i_fp_unpack (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .op_a        (op_a),
        .op_b        (op_b),
        .instruction (instruction),
        .dn          (i_align_if.source)
    );

    fp_arith i_fp_arith (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .up     (i_align_if.sink),
        .dn     (i_arith_if.source)
    );

    fp_normalize i_fp_normalize (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .up     (i_arith_if.sink),
        .dn     (i_norm_if.source)
    );

    fp_pack i_fp_pack (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .up     (i_norm_if.sink),
        .result (result),
        .valid  (valid)
    );

endmodule

`default_nettype wire

/* testbench/fp_alu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_alu_chk (
    input logic                clk,
    input logic                rst,
    input logic                enable,
    input alu_op_pkg::alu_op_e op,
    input fp_types_pkg::fp32_t result,
    input logic                valid
);
    import alu_op_pkg::*;

    int fail_count = 0;

    // Synchronous reset empties the last stage on the next edge
    a_reset_valid: assert property (@(posedge clk) rst |=> !valid)
        else begin
            fail_count++;
            $error("valid high after a reset cycle");
        end

    // Compare operations produce a single bit
    a_cmp_bool: assert property (@(posedge clk) disable iff (rst)
        (valid && (op == FEQ || op == FSLT)) |-> (result[31:1] == '0))
        else begin
            fail_count++;
            $error("compare result is not 0 or 1");
        end

    a_abs_sign: assert property (@(posedge clk) disable iff (rst)
        (valid && op == FABS) |-> !result.sign)
        else begin
            fail_count++;
            $error("absolute value with the sign bit set");
        end

    // A frozen pipeline keeps its output
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (!enable && valid) |=> ($stable(result) && valid))
        else begin
            fail_count++;
            $error("output moved while enable was low");
        end

endmodule

bind fp_pack fp_alu_chk i_fp_alu_chk (
    .clk    (clk),
    .rst    (rst),
    .enable (enable),
    .op     (op_q),
    .result (result),
    .valid  (valid)
);

`default_nettype wire

/* testbench/fp_alu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_defs.svh"

module fp_alu_tb;
    import fp_types_pkg::*;
    import alu_op_pkg::*;

    typedef struct {
        logic [31:0] value;
        int          tag;
        alu_op_e     op;
        fp32_t       a;
        fp32_t       b;
    } exp_item_t;

    localparam int TOTAL_ITEMS = 8 + 200 + 200 + 40 + 60 + 200 + 6 * 4;
    localparam int WATCHDOG_NS = (TOTAL_ITEMS * 4 + 100) * 20;

    logic    clk;
    logic    rst;
    logic    enable;
    fp32_t   op_a;
    fp32_t   op_b;
    alu_op_e instruction;
    fp32_t   result;
    logic    valid;

    logic [31:0] lcg_state = 32'h90d1;
    exp_item_t   expect_q[$];
    exp_item_t   prev_item;
    logic        prev_en;
    fp32_t       last_result;
    logic        last_valid;
    int          en_edges;
    int          cur_test;
    int          checks_done;
    int          error_count;
    int          assert_fails;
    int          test_errors[6];
    string       test_names[6] = '{"reset_fill", "add_sub", "mul", "sign_ops",
                                   "compare", "stall"};

    fp_alu i_fp_alu (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .op_a        (op_a),
        .op_b        (op_b),
        .instruction (instruction),
        .result      (result),
        .valid       (valid)
    );

    always #10 clk = ~clk;

    // ==================================================
    // Random numbers and reference model
    // ==================================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (lcg_next() >> 8) % n;
    endfunction

    // Exponents stay in 64..190 so products neither overflow nor underflow
    function automatic fp32_t rand_operand();
        fp32_t v;
        v.sign = lcg_next() >> 31;
        v.exp  = 8'(64 + rand_below(127));
        v.frac = 23'(lcg_next() >> 9);
        return v;
    endfunction

    function automatic logic [31:0] pack_result(input logic s, input int e,
                                                input logic [24:0] sig);
        if (e >= `FP_EXP_INF) begin
            return {s, 8'hff, 23'd0};
        end
        if (e == 0) begin
            return {s, 31'd0};
        end
        return {s, 8'(e), sig[22:0]};
    endfunction

    function automatic logic [31:0] model(input alu_op_e op, input fp32_t a, input fp32_t b);
        int          ea;
        int          eb;
        int          e;
        int          d;
        int          p;
        logic        s;
        logic        sb;
        logic        g;
        logic        r;
        logic        st;
        logic [24:0] ma;
        logic [24:0] mb;
        logic [24:0] sum;
        logic [47:0] prod;
        ea = a.exp;
        eb = b.exp;
        ma = {2'b01, a.frac};
        mb = {2'b01, b.frac};
        sb = b.sign ^ (op == FSUB);
        case (op)
            FADD, FSUB: begin
                // Align to the larger exponent and drop the shifted-out bits
                if (ea >= eb) begin
                    d  = ea - eb;
                    e  = ea;
                    mb = (d > 24) ? 25'd0 : mb >> d;
                end else begin
                    d  = eb - ea;
                    e  = eb;
                    ma = (d > 24) ? 25'd0 : ma >> d;
                end
                if (a.sign == sb) begin
                    sum = ma + mb;
                    s   = a.sign;
                end else if (ma >= mb) begin
                    sum = ma - mb;
                    s   = a.sign;
                end else begin
                    sum = mb - ma;
                    s   = sb;
                end
                if (sum == 0) begin
                    return 32'd0;
                end
                if (sum[24]) begin
                    return pack_result(s, e + 1, sum >> 1);
                end
                p = 23;
                while (!sum[p]) begin
                    p--;
                end
                if (23 - p > e) begin
                    return 32'd0;
                end
                return pack_result(s, e - (23 - p), sum << (23 - p));
            end
            FMUL: begin
                prod = 48'(ma[23:0]) * 48'(mb[23:0]);
                e    = ea + eb - `FP_EXP_BIAS;
                s    = a.sign ^ b.sign;
                if (prod[47]) begin
                    sum = {1'b0, prod[47:24]};
                    g   = prod[23];
                    r   = prod[22];
                    st  = |prod[21:0];
                    e   = e + 1;
                end else begin
                    sum = {1'b0, prod[46:23]};
                    g   = prod[22];
                    r   = prod[21];
                    st  = |prod[20:0];
                end
                // Nearest even
                if (g && (r || st || sum[0])) begin
                    sum = sum + 25'd1;
                end
                if (sum[24]) begin
                    e   = e + 1;
                    sum = sum >> 1;
                end
                return pack_result(s, e, sum);
            end
            FNEG: return {~a.sign, a[30:0]};
            FABS: return {1'b0, a[30:0]};
            FEQ: return {31'd0, (a[30:0] == 0 && b[30:0] == 0) || a == b};
            FSLT: begin
                if (a[30:0] == 0 && b[30:0] == 0) begin
                    return 32'd0;
                end
                if (a.sign != b.sign) begin
                    return {31'd0, a.sign};
                end
                return {31'd0, a.sign ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0])};
            end
            default: return 32'd0;
        endcase
    endfunction

    // ==================================================
    // Per-cycle driver and scoreboard
    // ==================================================
    task automatic note_error(input int tag);
        error_count++;
        test_errors[tag]++;
    endtask

    task automatic cycle(input logic en, input alu_op_e op, input fp32_t a, input fp32_t b);
        exp_item_t it;
        @(posedge clk);
        enable      <= en;
        instruction <= op;
        op_a        <= a;
        op_b        <= b;
        @(negedge clk);
        // Outcome of the edge that took the previous cycle's inputs
        if (prev_en) begin
            en_edges++;
            expect_q.push_back(prev_item);
        end
        if (valid !== (en_edges >= 4)) begin
            $display("ERROR %s: valid expected %b actual %b after %0d enabled edges",
                     test_names[cur_test], en_edges >= 4, valid, en_edges);
            note_error(cur_test);
        end
        if (!prev_en && (result !== last_result || valid !== last_valid)) begin
            $display("ERROR %s: output changed while enable was low, was %h now %h",
                     test_names[cur_test], last_result, result);
            note_error(cur_test);
        end
        if (prev_en && valid) begin
            if (expect_q.size() == 0) begin
                $display("ERROR %s: valid result with no item in flight",
                         test_names[cur_test]);
                note_error(cur_test);
            end else begin
                it = expect_q.pop_front();
                checks_done++;
                if (result !== it.value) begin
                    $display("ERROR %s: %s a=%h b=%h expected %h actual %h",
                             test_names[it.tag], it.op.name(), it.a, it.b, it.value, result);
                    note_error(it.tag);
                end
            end
        end
        last_result     = result;
        last_valid      = valid;
        prev_en         = en;
        prev_item.value = model(op, a, b);
        prev_item.tag   = cur_test;
        prev_item.op    = op;
        prev_item.a     = a;
        prev_item.b     = b;
    endtask

    task automatic run_test(input int idx, input int count);
        fp32_t   a;
        fp32_t   b;
        alu_op_e op;
        logic    en;
        int      gap;
        cur_test = idx;
        gap      = 0;
        for (int i = 0; i < count; i++) begin
            a  = rand_operand();
            b  = rand_operand();
            op = alu_op_e'(rand_below(7));
            en = (rand_below(4) != 0);
            case (idx)
                1: begin
                    op = rand_below(2) ? FSUB : FADD;
                    case (rand_below(8))
                        // Exact cancellation
                        0: b = {a.sign ^ (op == FADD), a[30:0]};
                        1, 2: b.exp = a.exp;
                        default: ;
                    endcase
                end
                2: op = FMUL;
                3: begin
                    op = rand_below(2) ? FNEG : FABS;
                    if (rand_below(4) == 0) begin
                        a = {a.sign, 31'd0};
                    end
                end
                4: begin
                    op = rand_below(2) ? FEQ : FSLT;
                    case (rand_below(4))
                        0: b = a;
                        1: begin
                            a = rand_below(2) ? 32'h8000_0000 : 32'h0;
                            b = {~a.sign, 31'd0};
                        end
                        2: b = {~a.sign, a[30:0]};
                        default: ;
                    endcase
                end
                5: begin
                    if (gap > 0) begin
                        en  = 1'b0;
                        gap = gap - 1;
                    end else begin
                        en  = 1'b1;
                        gap = (rand_below(3) == 0) ? rand_below(6) : 0;
                    end
                end
                default: ;
            endcase
            cycle(en, op, a, b);
        end
        // Push the last real item out to the result port
        repeat (4) cycle(1'b1, FABS, 32'h0, 32'h0);
        $display("test %-10s %4d items  %0d errors  %s", test_names[idx], count,
                 test_errors[idx], (test_errors[idx] == 0) ? "ok" : "FAIL");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        enable       = 1'b0;
        op_a         = '0;
        op_b         = '0;
        instruction  = FADD;
        prev_en      = 1'b0;
        prev_item    = '{32'd0, 0, FADD, 32'd0, 32'd0};
        en_edges     = 0;
        cur_test     = 0;
        checks_done  = 0;
        error_count  = 0;
        assert_fails = 0;
        test_errors  = '{0, 0, 0, 0, 0, 0};

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (valid !== 1'b0 || result !== 32'd0) begin
            $display("ERROR reset_fill: after reset expected valid 0 result 0, actual %b %h",
                     valid, result);
            note_error(0);
        end
        last_result = result;
        last_valid  = valid;

        run_test(0, 8);
        run_test(1, 200);
        run_test(2, 200);
        run_test(3, 40);
        run_test(4, 60);
        run_test(5, 200);

        assert_fails = i_fp_alu.i_fp_pack.i_fp_alu_chk.fail_count;
        $display("Summary: %0d results checked, %0d errors, %0d assertion failures",
                 checks_done, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/fp_types_pkg.sv
rtl/alu_op_pkg.sv
rtl/fp_pipe_if.sv
rtl/fp_unpack.sv
rtl/fp_arith.sv
rtl/fp_normalize.sv
rtl/fp_pack.sv
rtl/fp_alu.sv
testbench/fp_alu_chk.sv
testbench/fp_alu_tb.sv

/* Bender.yml */
package:
  name: fp_alu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fp_types_pkg.sv
      - rtl/alu_op_pkg.sv
      - rtl/fp_pipe_if.sv
      - rtl/fp_unpack.sv
      - rtl/fp_arith.sv
      - rtl/fp_normalize.sv
      - rtl/fp_pack.sv
      - rtl/fp_alu.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/fp_alu_chk.sv
      - testbench/fp_alu_tb.sv
